// ==== Makefile ====
# Verilator build and run of the transmit channel allocator testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tx_channel_alloc_tb
FILELIST  := files.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== files.f ====
logic/alloc_cfg_pkg.sv
logic/alloc_data_pkg.sv
logic/element_packer.sv
logic/chunk_fifo.sv
logic/lane_spreader.sv
logic/tx_channel_alloc.sv
test/tx_channel_alloc_checker.sv
test/tx_channel_alloc_tb.sv

// ==== logic/alloc_cfg_pkg.sv ====
// configuration constants of the transmit channel allocator
// and the packed configuration word that drives it
`default_nettype none

package alloc_cfg_pkg;

  // number of physical serial channels
  localparam int unsigned num_channels = 4;

  // width of the idle counter used for auto-flush
  localparam int unsigned flush_cnt_width = 8;

  // the whole word may only change while the allocator is empty
  // flush and clear are single cycle pulses
  typedef struct packed {
    logic [num_channels-1:0]    channel_en;
    logic                       auto_flush_en;
    logic [flush_cnt_width-1:0] auto_flush_count;
    logic                       flush;
    logic                       clear;
  } tx_cfg_t;

endpackage : alloc_cfg_pkg

`default_nettype wire

// ==== logic/alloc_data_pkg.sv ====
// datapath types of the transmit channel allocator
// element, beat and chunk types and the sizing constants
`default_nettype none

package alloc_data_pkg;

  import alloc_cfg_pkg::*;

  // one element is carried by one channel per transfer
  localparam int unsigned elem_width = 8;

  // the packer holds up to two beats worth of elements
  localparam int unsigned stage_depth = 2 * num_channels;
  localparam int unsigned fill_width  = $clog2(stage_depth + 1);

  // chunk FIFO sizing
  localparam int unsigned fifo_depth     = 4;
  localparam int unsigned fifo_ptr_width = $clog2(fifo_depth);
  localparam int unsigned fifo_cnt_width = $clog2(fifo_depth + 1);

  typedef logic [elem_width-1:0] element_t;

  // element 0 sits in the lowest bits, on input and on the channels alike
  typedef element_t [num_channels-1:0] beat_t;

  // holds 0 up to num_channels
  typedef logic [$clog2(num_channels + 1)-1:0] count_t;

  // a chunk packs its valid elements from index 0 upwards
  typedef struct packed {
    beat_t  elems;
    count_t count;
  } chunk_t;

endpackage : alloc_data_pkg

`default_nettype wire

// ==== logic/chunk_fifo.sv ====
// chunk FIFO between packer and spreader
// circular buffer with valid/ready on push and pop side
`timescale 1ns/100ps
`default_nettype none

module chunk_fifo
  import alloc_cfg_pkg::*;
  import alloc_data_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   clear_i,
  input  chunk_t push_chunk_i,
  input  logic   push_valid_i,
  output logic   push_ready_o,
  output chunk_t pop_chunk_o,
  output logic   pop_valid_o,
  input  logic   pop_ready_i
);

  chunk_t [fifo_depth-1:0] mem_q;

  logic [fifo_ptr_width-1:0] wr_ptr_q;
  logic [fifo_ptr_width-1:0] rd_ptr_q;
  logic [fifo_cnt_width-1:0] cnt_q;

  logic push;
  logic pop;

  // when full, a pop in the same cycle frees the slot being written
  assign push_ready_o = (cnt_q != fifo_cnt_width'(fifo_depth)) || pop_ready_i;
  assign pop_valid_o  = (cnt_q != '0);
  assign pop_chunk_o  = mem_q[rd_ptr_q];

  assign push = push_valid_i && push_ready_o;
  assign pop  = pop_valid_o && pop_ready_i;

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      // depth is a power of two so the pointers wrap on their own
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop && !push) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // storage array, written behind the write pointer
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_chunk_i;
    end
  end

endmodule : chunk_fifo

`default_nettype wire

// ==== logic/element_packer.sv ====
// element packer of the transmit allocator
// stages incoming beats and cuts them into chunks of k elements,
// where k is the number of enabled channels, with manual and auto flush
`timescale 1ns/100ps
`default_nettype none

module element_packer
  import alloc_cfg_pkg::*;
  import alloc_data_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  input  tx_cfg_t cfg_i,
  input  beat_t   in_beat_i,
  input  logic    in_valid_i,
  output logic    in_ready_o,
  output chunk_t  chunk_o,
  output logic    chunk_valid_o,
  input  logic    chunk_ready_i
);

  // staging buffer, index 0 holds the oldest element
  element_t [stage_depth-1:0] stage_q, stage_d;
  logic [fill_width-1:0]      fill_q, fill_d;
  logic [fill_width-1:0]      rest;

  logic [flush_cnt_width-1:0] idle_q, idle_d;
  logic                       flush_pend_q, flush_pend_d;

  // registered chunk output
  chunk_t chunk_q, chunk_d;
  logic   chunk_valid_q, chunk_valid_d;

  count_t k;
  count_t take;
  count_t n;
  logic   accept;
  logic   load_ok;
  logic   auto_due;
  logic   flush_due;
  logic   full_due;
  logic   emit;

  // popcount of the channel enables gives the chunk size
  always_comb begin
    k = '0;
    for (int c = 0; c < num_channels; c++) begin
      k = k + count_t'(cfg_i.channel_en[c]);
    end
  end

  // a beat fits only if a full beat of free slots is left
  assign in_ready_o = (fill_q <= fill_width'(stage_depth - num_channels));

  always_comb begin
    accept    = in_valid_i && in_ready_o;
    // the output register can take a new chunk when empty or being drained
    load_ok   = !chunk_valid_q || chunk_ready_i;
    auto_due  = cfg_i.auto_flush_en && (idle_q == cfg_i.auto_flush_count);
    flush_due = cfg_i.flush || flush_pend_q || auto_due;
    full_due  = (k != '0) && (fill_q >= fill_width'(k));

    // min(fill, k) elements leave the buffer
    take = full_due ? k : count_t'(fill_q);
    emit = load_ok && (k != '0) && (full_due || ((fill_q != '0) && flush_due));
    n    = emit ? take : '0;
    rest = fill_q - fill_width'(n);

    // drop the emitted elements and move the rest down to index 0
    for (int j = 0; j < stage_depth; j++) begin
      if (j + int'(n) < stage_depth) begin
        stage_d[j] = stage_q[j + int'(n)];
      end else begin
        stage_d[j] = '0;
      end
    end

    // the new beat lands right behind whatever stays staged
    if (accept) begin
      for (int i = 0; i < num_channels; i++) begin
        stage_d[int'(rest) + i] = in_beat_i[i];
      end
    end
    fill_d = rest + (accept ? fill_width'(num_channels) : '0);

    // a chunk that was taken this cycle goes away unless replaced
    chunk_d       = chunk_q;
    chunk_valid_d = chunk_valid_q && !chunk_ready_i;
    if (emit) begin
      chunk_valid_d = 1'b1;
      chunk_d.count = take;
      for (int i = 0; i < num_channels; i++) begin
        chunk_d.elems[i] = (i < int'(take)) ? stage_q[i] : '0;
      end
    end

    // idle time only runs while something is staged and nothing arrives
    // and it stops at the configured count so the flush stays due
    if (accept || (fill_q == '0)) begin
      idle_d = '0;
    end else if (idle_q != cfg_i.auto_flush_count) begin
      idle_d = idle_q + 1'b1;
    end else begin
      idle_d = idle_q;
    end

    // a manual flush waits until the staged data is gone
    flush_pend_d = cfg_i.flush || flush_pend_q;
    if ((fill_q == '0) || (emit && (rest == '0))) begin
      flush_pend_d = 1'b0;
    end

    // clear throws away staged data and the pending output chunk
    if (cfg_i.clear) begin
      fill_d        = '0;
      idle_d        = '0;
      flush_pend_d  = 1'b0;
      chunk_valid_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      fill_q        <= '0;
      idle_q        <= '0;
      flush_pend_q  <= 1'b0;
      chunk_valid_q <= 1'b0;
    end else begin
      fill_q        <= fill_d;
      idle_q        <= idle_d;
      flush_pend_q  <= flush_pend_d;
      chunk_valid_q <= chunk_valid_d;
    end
  end

  // staged elements and the outgoing chunk payload
  always_ff @(posedge clk_i) begin
    stage_q <= stage_d;
    chunk_q <= chunk_d;
  end

  assign chunk_o       = chunk_q;
  assign chunk_valid_o = chunk_valid_q;

endmodule : element_packer

`default_nettype wire

// ==== logic/lane_spreader.sv ====
// lane spreader of the transmit allocator
// maps chunk elements onto the enabled channels in ascending order
// and pops the chunk only when all driven channels are ready together
`timescale 1ns/100ps
`default_nettype none

module lane_spreader
  import alloc_cfg_pkg::*;
  import alloc_data_pkg::*;
(
  input  logic [num_channels-1:0] channel_en_i,
  input  chunk_t                  chunk_i,
  input  logic                    chunk_valid_i,
  output logic                    chunk_ready_o,
  output beat_t                   ch_data_o,
  output logic [num_channels-1:0] ch_valid_o,
  input  logic [num_channels-1:0] ch_ready_i
);

  // index of the next chunk element to place
  count_t elem_idx;

  always_comb begin
    elem_idx   = '0;
    ch_data_o  = '0;
    ch_valid_o = '0;
    for (int c = 0; c < num_channels; c++) begin
      if (channel_en_i[c]) begin
        // the n-th enabled channel carries element n of the chunk
        if (elem_idx < chunk_i.count) begin
          ch_data_o[c]  = chunk_i.elems[elem_idx];
          ch_valid_o[c] = chunk_valid_i;
        end
        elem_idx = elem_idx + 1'b1;
      end
      // disabled channels and channels past the chunk count stay idle
    end
  end

  // sync barrier
  // every channel that shows valid must also be ready in the same cycle,
  // otherwise the head chunk stays in the FIFO and the outputs hold
  assign chunk_ready_o = chunk_valid_i && ((ch_valid_o & ~ch_ready_i) == '0);

endmodule : lane_spreader

`default_nettype wire

// ==== logic/tx_channel_alloc.sv ====
// transmit channel allocator top level
// packer feeds the chunk FIFO, the spreader drains it onto the channels
`timescale 1ns/100ps
`default_nettype none

module tx_channel_alloc
  import alloc_cfg_pkg::*;
  import alloc_data_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  tx_cfg_t                 cfg_i,
  input  beat_t                   in_beat_i,
  input  logic                    in_valid_i,
  output logic                    in_ready_o,
  output beat_t                   ch_data_o,
  output logic [num_channels-1:0] ch_valid_o,
  input  logic [num_channels-1:0] ch_ready_i
);

  // packer to FIFO
  chunk_t packer_chunk;
  logic   packer_valid;
  logic   fifo_push_ready;

  // FIFO head to spreader
  chunk_t head_chunk;
  logic   head_valid;
  logic   spread_pop;

  element_packer element_packer_i (
    .clk_i         ( clk_i           ),
    .rst_ni        ( rst_ni          ),
    .cfg_i         ( cfg_i           ),
    .in_beat_i     ( in_beat_i       ),
    .in_valid_i    ( in_valid_i      ),
    .in_ready_o    ( in_ready_o      ),
    .chunk_o       ( packer_chunk    ),
    .chunk_valid_o ( packer_valid    ),
    .chunk_ready_i ( fifo_push_ready )
  );

  // clear empties the buffered chunks together with the packer
  chunk_fifo chunk_fifo_i (
    .clk_i        ( clk_i           ),
    .rst_ni       ( rst_ni          ),
    .clear_i      ( cfg_i.clear     ),
    .push_chunk_i ( packer_chunk    ),
    .push_valid_i ( packer_valid    ),
    .push_ready_o ( fifo_push_ready ),
    .pop_chunk_o  ( head_chunk      ),
    .pop_valid_o  ( head_valid      ),
    .pop_ready_i  ( spread_pop      )
  );

  lane_spreader lane_spreader_i (
    .channel_en_i  ( cfg_i.channel_en ),
    .chunk_i       ( head_chunk       ),
    .chunk_valid_i ( head_valid       ),
    .chunk_ready_o ( spread_pop       ),
    .ch_data_o     ( ch_data_o        ),
    .ch_valid_o    ( ch_valid_o       ),
    .ch_ready_i    ( ch_ready_i       )
  );

endmodule : tx_channel_alloc

`default_nettype wire

// ==== test/alloc_tests.txt ====
# one command per line, lines starting with # are skipped
# config <mask hex> <auto_en> <auto_count dec> | word <b0> <b1> <b2> <b3> hex, b0 is element 0
# flush | idle <cycles dec> | expect_none <cycles dec> | drain
# all channels enabled, bytes arrive in sent order
config f 0 0
word 00 01 02 03
word 04 05 06 07
word 08 09 0a 0b
drain
# upper two channels only, every beat is a full pair
config c 0 0
word 10 11 12 13
word 14 15 16 17
drain
# three channels, two bytes stay staged until the flush
config 7 0 0
word 20 21 22 23
word 24 25 26 27
idle 40
expect_none 20
flush
drain
# auto-flush on a sparse mask sends the leftover on its own
config b 1 12
word 30 31 32 33
word 34 35 36 37
drain
config 2 1 5
word 38 39 3a 3b
idle 3
word 3c 3d 3e 3f
drain
# back-to-back burst against random channel back-pressure
config f 0 0
word 40 41 42 43
word 44 45 46 47
word 48 49 4a 4b
word 4c 4d 4e 4f
word 50 51 52 53
word 54 55 56 57
drain

// ==== test/tx_channel_alloc_checker.sv ====
// protocol assertions on the channel side of the transmit allocator
// and the bind that attaches them to the top level
`timescale 1ns/100ps
`default_nettype none

module tx_channel_alloc_checker
  import alloc_cfg_pkg::*;
  import alloc_data_pkg::*;
(
  input logic                    clk_i,
  input logic                    rst_ni,
  input tx_cfg_t                 cfg_i,
  input beat_t                   ch_data_i,
  input logic [num_channels-1:0] ch_valid_i,
  input logic [num_channels-1:0] ch_ready_i
);

  logic order_ok;
  logic gap_seen;

  // number of assertion failures so far
  int unsigned fail_count = 0;

  // once an enabled channel is idle no higher enabled channel may be valid
  always_comb begin
    order_ok = 1'b1;
    gap_seen = 1'b0;
    for (int c = 0; c < num_channels; c++) begin
      if (cfg_i.channel_en[c]) begin
        if (ch_valid_i[c] && gap_seen) begin
          order_ok = 1'b0;
        end
        if (!ch_valid_i[c]) begin
          gap_seen = 1'b1;
        end
      end
    end
  end

  valid_in_mask: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((ch_valid_i & ~cfg_i.channel_en) == '0))
    else begin
      fail_count++;
      $error("a disabled channel shows valid");
    end

  lowest_first: assert property (@(posedge clk_i) disable iff (!rst_ni) order_ok)
    else begin
      fail_count++;
      $error("valid channels are not the lowest enabled ones");
    end

  // a stalled beat keeps its valids and data until every valid channel is ready
  hold_stable: assert property (@(posedge clk_i) disable iff (!rst_ni || cfg_i.clear)
    ((ch_valid_i & ~ch_ready_i) != '0) |=> ($stable(ch_valid_i) && $stable(ch_data_i)))
    else begin
      fail_count++;
      $error("channel beat changed while it was stalled");
    end

  quiet_reset: assert property (@(posedge clk_i)
    (!rst_ni || $rose(rst_ni)) |-> (ch_valid_i == '0))
    else begin
      fail_count++;
      $error("channel valid during or right after reset");
    end

endmodule : tx_channel_alloc_checker

bind tx_channel_alloc tx_channel_alloc_checker tx_channel_alloc_checker_i (
  .clk_i      ( clk_i      ),
  .rst_ni     ( rst_ni     ),
  .cfg_i      ( cfg_i      ),
  .ch_data_i  ( ch_data_o  ),
  .ch_valid_i ( ch_valid_o ),
  .ch_ready_i ( ch_ready_i )
);

`default_nettype wire

// ==== test/tx_channel_alloc_tb.sv ====
// testbench of the transmit channel allocator
// runs the command file, keeps the sent bytes in order and checks every channel beat
`timescale 1ns/100ps
`default_nettype none

module tx_channel_alloc_tb
  import alloc_cfg_pkg::*;
  import alloc_data_pkg::*;
();

  logic                    clk_i;
  logic                    rst_ni;
  tx_cfg_t                 cfg;
  beat_t                   in_beat;
  logic                    in_valid;
  logic                    in_ready;
  beat_t                   ch_data;
  logic [num_channels-1:0] ch_valid;
  logic [num_channels-1:0] ch_ready;

  // one entry per command line of the file
  string       cmd_q[$];
  logic [31:0] arg_a_q[$];
  logic [31:0] arg_b_q[$];
  logic [31:0] arg_c_q[$];

  // bytes that went in but have not shown up on a channel yet, oldest first
  element_t sent_q[$];

  int   mon_errors = 0;
  int   drv_errors = 0;
  int   beats = 0;
  int   cycles = 0;
  int   test_cycles = 0;
  int   limit = 1000000;
  int   expected_k;
  logic partial_ok;
  logic timed_out = 1'b0;

  tx_channel_alloc tx_channel_alloc_i (
    .clk_i      ( clk_i    ),
    .rst_ni     ( rst_ni   ),
    .cfg_i      ( cfg      ),
    .in_beat_i  ( in_beat  ),
    .in_valid_i ( in_valid ),
    .in_ready_o ( in_ready ),
    .ch_data_o  ( ch_data  ),
    .ch_valid_o ( ch_valid ),
    .ch_ready_i ( ch_ready )
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // every channel is ready with a chance of three in four, each cycle anew
  initial begin
    void'($urandom(32'ha808));
    ch_ready = '1;
    forever begin
      @(negedge clk_i);
      ch_ready = num_channels'($urandom) | num_channels'($urandom);
    end
  end

  task automatic load_tests();
    int          fd;
    string       line;
    string       cmd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
    fd = $fopen("test/alloc_tests.txt", "r");
    if (fd == 0) begin
      drv_errors++;
      $display("the test command file could not be opened");
      return;
    end
    while ($fgets(line, fd) != 0) begin
      a = '0;
      b = '0;
      c = '0;
      d = '0;
      if ($sscanf(line, "%s", cmd) < 1 || cmd.substr(0, 0) == "#") begin
        continue;
      end
      if (cmd == "config") begin
        void'($sscanf(line, "%s %h %d %d", cmd, a, b, c));
      end else if (cmd == "word") begin
        void'($sscanf(line, "%s %h %h %h %h", cmd, a, b, c, d));
        // first byte goes to element 0 in the low bits
        a = {d[7:0], c[7:0], b[7:0], a[7:0]};
        test_cycles += 1;
      end else if (cmd == "idle" || cmd == "expect_none") begin
        void'($sscanf(line, "%s %d", cmd, a));
        test_cycles += int'(a);
      end else if (cmd != "flush" && cmd != "drain") begin
        drv_errors++;
        $display("unknown command %s in the test command file", cmd);
        continue;
      end
      cmd_q.push_back(cmd);
      arg_a_q.push_back(a);
      arg_b_q.push_back(b);
      arg_c_q.push_back(c);
    end
    $fclose(fd);
  endtask

  // holds the beat until the packer takes it, ready is registered so it
  // already shows at the falling edge what the next rising edge will see
  task automatic send_word(input beat_t beat);
    logic ready_now;
    in_beat   = beat;
    in_valid  = 1'b1;
    ready_now = 1'b0;
    while (!ready_now) begin
      ready_now = in_ready;
      @(negedge clk_i);
    end
    in_valid = 1'b0;
    for (int i = 0; i < num_channels; i++) begin
      sent_q.push_back(beat[i]);
    end
  endtask

  task automatic expect_quiet(input int n);
    repeat (n) begin
      assert (ch_valid == '0) else begin
        drv_errors++;
        $display("Error at %0t: ch_valid_o = %b, expected %b", $time, ch_valid, 4'b0000);
      end
      @(negedge clk_i);
    end
  endtask

  task automatic run_command(input int idx);
    string       cmd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    cmd = cmd_q[idx];
    a   = arg_a_q[idx];
    b   = arg_b_q[idx];
    c   = arg_c_q[idx];
    if (cmd == "config") begin
      cfg.channel_en       = a[num_channels-1:0];
      cfg.auto_flush_en    = b[0];
      cfg.auto_flush_count = c[flush_cnt_width-1:0];
      expected_k           = $countones(a[num_channels-1:0]);
      // short beats can only come from a flush
      partial_ok           = b[0];
    end else if (cmd == "word") begin
      send_word(beat_t'(a));
    end else if (cmd == "flush") begin
      partial_ok = 1'b1;
      cfg.flush  = 1'b1;
      @(negedge clk_i);
      cfg.flush  = 1'b0;
    end else if (cmd == "idle") begin
      repeat (a) @(negedge clk_i);
    end else if (cmd == "expect_none") begin
      expect_quiet(int'(a));
    end else begin
      while (sent_q.size() != 0) @(negedge clk_i);
    end
  endtask

  // valid channels take the next sent bytes in ascending channel order
  task automatic check_beat();
    int       used;
    element_t exp_byte;
    used = $countones(ch_valid);
    assert ((ch_valid & ~cfg.channel_en) == '0) else begin
      mon_errors++;
      $display("Error at %0t: ch_valid_o = %b, expected within %b", $time, ch_valid,
               cfg.channel_en);
    end
    assert (used == expected_k || (partial_ok && used < expected_k)) else begin
      mon_errors++;
      $display("Error at %0t: ch_valid_o count = %0d, expected %0d", $time, used, expected_k);
    end
    // a manual flush sends the leftover as one short beat and no more
    if (used < expected_k) begin
      partial_ok = cfg.auto_flush_en;
    end
    for (int c = 0; c < num_channels; c++) begin
      if (ch_valid[c]) begin
        assert (sent_q.size() != 0) else begin
          mon_errors++;
          $display("channel %0d carried byte %h that was never sent", c, ch_data[c]);
        end
        if (sent_q.size() != 0) begin
          exp_byte = sent_q.pop_front();
          assert (ch_data[c] == exp_byte) else begin
            mon_errors++;
            $display("Error at %0t: ch_data_o[%0d] = %h, expected %h", $time, c, ch_data[c],
                     exp_byte);
          end
        end
      end
    end
    beats++;
  endtask

  task automatic finish_run();
    int total;
    total = mon_errors + drv_errors + int'(timed_out) +
            int'(tx_channel_alloc_i.tx_channel_alloc_checker_i.fail_count);
    $display("errors: %0d, beats checked: %0d, bytes left: %0d", total, beats, sent_q.size());
    if (total == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  endtask

  // the barrier takes a beat only when every valid channel is ready
  always @(posedge clk_i) begin
    cycles++;
    if (rst_ni && (ch_valid != '0) && ((ch_valid & ~ch_ready) == '0)) begin
      check_beat();
    end
    if (cycles >= limit) begin
      timed_out = 1'b1;
      $display("run stopped after %0d cycles before all commands were done", cycles);
      finish_run();
    end
  end

  initial begin
    rst_ni         = 1'b0;
    cfg            = '0;
    cfg.channel_en = '1;
    in_beat        = '0;
    in_valid       = 1'b0;
    partial_ok     = 1'b0;
    expected_k     = num_channels;
    load_tests();
    limit = 20 * test_cycles + 200;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    // the staging buffer starts empty so a beat can be taken at once
    assert (in_ready == 1'b1) else begin
      drv_errors++;
      $display("Error at %0t: in_ready_o = %b, expected %b", $time, in_ready, 1'b1);
    end
    for (int i = 0; i < cmd_q.size(); i++) begin
      run_command(i);
    end
    repeat (4) @(negedge clk_i);
    assert (sent_q.size() == 0) else begin
      drv_errors++;
      $display("%0d sent bytes never reached a channel", sent_q.size());
    end
    finish_run();
  end

endmodule : tx_channel_alloc_tb

`default_nettype wire
